// ==== include/snn_macros.svh ====
`ifndef SNN_MACROS_SVH
`define SNN_MACROS_SVH

// --------------------
// network size
// --------------------
`define SNN_PRE_NEURONS     16   // input neurons, one weight row each
`define SNN_POST_NEURONS    4    // output neurons, all updated in parallel
`define SNN_TIME_STEPS      4    // steps per sample

// --------------------
// datapath widths
// --------------------
`define SNN_WEIGHT_WIDTH    8    // signed
`define SNN_MEM_WIDTH       12   // signed membrane, saturating
`define SNN_CNT_WIDTH       3    // spikes per neuron per sample
`define SNN_GOODNESS_WIDTH  8    // sum of squared counts

// --------------------
// neuron and queue settings
// --------------------
`define SNN_THRESHOLD       64   // fire at or above
`define SNN_FIFO_DEPTH      8    // input event queue, power of two

`endif

// ==== verilog/snn_types_pkg.sv ====
`default_nettype none

`include "snn_macros.svh"

package snn_types_pkg;

    // --------------------
    // indices
    // --------------------
    typedef logic [$clog2(`SNN_PRE_NEURONS)-1:0]  pre_addr_t;   // input neuron
    typedef logic [$clog2(`SNN_POST_NEURONS)-1:0] post_idx_t;   // output neuron
    typedef logic [$clog2(`SNN_TIME_STEPS)-1:0]   tstep_t;

    // --------------------
    // neuron data
    // --------------------
    typedef logic signed [`SNN_WEIGHT_WIDTH-1:0] weight_t;
    // output neuron 0 sits in the low byte
    typedef logic [`SNN_POST_NEURONS*`SNN_WEIGHT_WIDTH-1:0] weight_row_t;
    typedef logic signed [`SNN_MEM_WIDTH-1:0] membrane_t;
    typedef logic [`SNN_CNT_WIDTH-1:0]        spike_cnt_t;
    typedef logic [`SNN_POST_NEURONS-1:0]     spike_vec_t;  // one bit per output
    typedef logic [`SNN_GOODNESS_WIDTH-1:0]   goodness_t;

    // --------------------
    // AER words
    // --------------------
    typedef logic [$bits(pre_addr_t):0] aer_in_t;   // msb set = time-step marker
    typedef logic [$bits(tstep_t)+$bits(post_idx_t)-1:0] aer_out_t;  // {tstep, idx}

endpackage

`default_nettype wire

// ==== verilog/snn_ctrl_pkg.sv ====
`default_nettype none

package snn_ctrl_pkg;

    // main sequencer
    typedef enum logic [2:0] {
        ctrl_idle,        // look at queue head
        ctrl_pop,         // pop neuron event, latch address
        ctrl_read_row,    // weight row read issued
        ctrl_integrate,   // row on bus, add to membranes
        ctrl_wait_out,    // output link must drain first
        ctrl_fire,        // threshold compare, pop marker
        ctrl_sample_end,  // goodness capture
        ctrl_clear        // neurons reset, finish pulse
    } ctrl_state_t;

    // four-phase handshake, rx and tx side
    typedef enum logic [1:0] {
        link_idle,
        link_req_wait,    // request seen / raised
        link_ack_wait     // waiting for the return-to-zero
    } link_state_t;

endpackage

`default_nettype wire

// ==== verilog/aer_in_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module aer_in_rx (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  snn_types_pkg::aer_in_t aer_in_addr,
    input  logic                   aer_in_req,
    output logic                   aer_in_ack,
    input  logic                   fifo_full,
    output logic                   push,
    output snn_types_pkg::aer_in_t push_data
);
    import snn_types_pkg::*;
    import snn_ctrl_pkg::*;

    logic        req_s1;
    logic        req_s2;    // synchronized request
    link_state_t state;
    logic        capture;   // take the word, one shot per request

    assign capture = (state == link_req_wait) && !fifo_full;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            req_s1     <= 1'b0;
            req_s2     <= 1'b0;
            state      <= link_idle;
            push       <= 1'b0;
            aer_in_ack <= 1'b0;
        end else begin
            req_s1 <= aer_in_req;
            req_s2 <= req_s1;
            push   <= 1'b0;                 // single-cycle strobe
            case (state)
                link_idle:     if (req_s2) state <= link_req_wait;
                link_req_wait: if (capture) begin   // ack held off while full
                    push       <= 1'b1;
                    aer_in_ack <= 1'b1;
                    state      <= link_ack_wait;
                end
                link_ack_wait: if (!req_s2) begin   // return to zero
                    aer_in_ack <= 1'b0;
                    state      <= link_idle;
                end
                default:       state <= link_idle;
            endcase
        end
    end

    // address is stable while req is high
    always_ff @(posedge CLK) begin
        if (capture) push_data <= aer_in_addr;
    end

endmodule

`default_nettype wire

// ==== verilog/event_scheduler.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "snn_macros.svh"

module event_scheduler (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   push,
    input  logic                   pop,
    input  snn_types_pkg::aer_in_t push_data,
    output snn_types_pkg::aer_in_t head,
    output logic                   empty,
    output logic                   full
);
    import snn_types_pkg::*;

    localparam int AW = $clog2(`SNN_FIFO_DEPTH);

    aer_in_t        mem_q [`SNN_FIFO_DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count_q;     // occupancy, 0..depth
    logic           do_push;
    logic           do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count_q == '0);
    assign full    = (count_q == (AW+1)'(`SNN_FIFO_DEPTH));
    assign head    = mem_q[rd_ptr];   // fall-through, no pop needed

    always_ff @(posedge CLK) begin
        if (do_push) mem_q[wr_ptr] <= push_data;
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // both or none
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/snn_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "snn_macros.svh"

module snn_controller (
    input  logic                     CLK,
    input  logic                     arst_n,
    input  logic                     empty,
    input  snn_types_pkg::aer_in_t   head,
    output logic                     pop,
    output logic                     row_rd,
    output snn_types_pkg::pre_addr_t row_addr,
    output logic                     integrate,
    output logic                     fire,
    output logic                     sample_end,
    input  logic                     out_busy,
    output logic                     out_load,
    output snn_types_pkg::tstep_t    cur_tstep,
    output logic                     one_sample_finish
);
    import snn_types_pkg::*;
    import snn_ctrl_pkg::*;

    localparam tstep_t LAST_TSTEP = tstep_t'(`SNN_TIME_STEPS - 1);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    pre_addr_t   addr_q;       // input neuron of the event in flight
    tstep_t      tstep_q;
    logic        done_q;       // last step fired, drain then close
    logic        out_load_q;
    logic        is_marker;

    assign is_marker = head[$bits(aer_in_t)-1];

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ctrl_idle: begin
                if (done_q)
                    state_nxt = ctrl_wait_out;   // busy is valid by now
                else if (!empty)
                    state_nxt = is_marker ? ctrl_wait_out : ctrl_pop;
            end
            ctrl_pop:        state_nxt = ctrl_read_row;
            ctrl_read_row:   state_nxt = ctrl_integrate;
            ctrl_integrate:  state_nxt = ctrl_idle;
            ctrl_wait_out: begin
                if (!out_busy) state_nxt = done_q ? ctrl_sample_end : ctrl_fire;
            end
            ctrl_fire:       state_nxt = ctrl_idle;   // load goes out next cycle
            ctrl_sample_end: state_nxt = ctrl_clear;
            ctrl_clear:      state_nxt = ctrl_idle;
            default:         state_nxt = ctrl_idle;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ctrl_idle;
            tstep_q    <= '0;
            done_q     <= 1'b0;
            out_load_q <= 1'b0;
        end else begin
            state      <= state_nxt;
            out_load_q <= (state == ctrl_fire);
            if (out_load_q) tstep_q <= tstep_q + 1'b1;  // wraps to 0 after last step
            if (state == ctrl_fire && tstep_q == LAST_TSTEP)
                done_q <= 1'b1;
            else if (state == ctrl_sample_end)
                done_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == ctrl_pop) addr_q <= head[$bits(pre_addr_t)-1:0];
    end

    // --------------------
    // strobes, decoded from state
    // --------------------
    assign pop               = (state == ctrl_pop) || (state == ctrl_fire); // marker pops at fire
    assign row_rd            = (state == ctrl_read_row);
    assign row_addr          = addr_q;
    assign integrate         = (state == ctrl_integrate);
    assign fire              = (state == ctrl_fire);
    assign sample_end        = (state == ctrl_sample_end);
    assign one_sample_finish = (state == ctrl_clear);   // goodness valid here
    assign out_load          = out_load_q;
    assign cur_tstep         = tstep_q;

endmodule

`default_nettype wire

// ==== verilog/synapse_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "snn_macros.svh"

module synapse_mem (
    input  logic                       CLK,
    input  logic                       wt_we,
    input  snn_types_pkg::pre_addr_t   wt_addr,
    input  snn_types_pkg::weight_row_t wt_data,
    input  logic                       row_rd,
    input  snn_types_pkg::pre_addr_t   row_addr,
    output snn_types_pkg::weight_row_t row_data
);
    import snn_types_pkg::*;

    weight_row_t mem_q [`SNN_PRE_NEURONS];   // one packed row per input neuron

    // write port, loaded between samples
    always_ff @(posedge CLK) begin
        if (wt_we) mem_q[wt_addr] <= wt_data;
    end

    // registered read, row valid one cycle after row_rd
    always_ff @(posedge CLK) begin
        if (row_rd) row_data <= mem_q[row_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/neuron_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "snn_macros.svh"

module neuron_array (
    input  logic                       CLK,
    input  logic                       arst_n,
    input  snn_types_pkg::weight_row_t row_data,
    input  logic                       integrate,
    input  logic                       fire,
    input  logic                       sample_end,
    output snn_types_pkg::spike_vec_t  spikes,
    output snn_types_pkg::goodness_t   goodness
);
    import snn_types_pkg::*;

    localparam int NP = `SNN_POST_NEURONS;
    localparam int MW = `SNN_MEM_WIDTH;

    membrane_t  mem_q   [NP];
    membrane_t  mem_add [NP];   // saturated membrane + weight
    spike_cnt_t cnt_q   [NP];
    logic       above   [NP];   // at or over threshold
    logic       clr_q;          // clear pending, cycle after sample_end
    goodness_t  good_nxt;

    // --------------------
    // saturating add
    // --------------------
    always_comb begin : sat_add
        logic signed [MW:0] sum;   // one guard bit
        weight_t            w;
        for (int i = 0; i < NP; i++) begin
            w   = row_data[i*`SNN_WEIGHT_WIDTH +: `SNN_WEIGHT_WIDTH];
            sum = mem_q[i] + w;
            if (sum[MW] != sum[MW-1])   // overflow, clamp by sign
                mem_add[i] = sum[MW] ? {1'b1, {(MW-1){1'b0}}} : {1'b0, {(MW-1){1'b1}}};
            else
                mem_add[i] = sum[MW-1:0];
            above[i] = (mem_q[i] >= `SNN_THRESHOLD);
        end
    end

    // goodness = sum of count squared
    always_comb begin
        good_nxt = '0;
        for (int i = 0; i < NP; i++) good_nxt = good_nxt + cnt_q[i] * cnt_q[i];
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NP; i++) begin
                mem_q[i] <= '0;
                cnt_q[i] <= '0;
            end
            spikes   <= '0;
            goodness <= '0;
            clr_q    <= 1'b0;
        end else begin
            clr_q <= sample_end;
            if (sample_end) goodness <= good_nxt;   // held until next sample
            for (int i = 0; i < NP; i++) begin
                if (clr_q) begin                    // new sample
                    mem_q[i] <= '0;
                    cnt_q[i] <= '0;
                end else if (integrate) begin
                    mem_q[i] <= mem_add[i];
                end else if (fire && above[i]) begin
                    mem_q[i] <= '0;                 // reset on spike
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                if (fire) spikes[i] <= above[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/aer_out_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module aer_out_tx (
    input  logic                    CLK,
    input  logic                    arst_n,
    input  logic                    out_load,
    input  snn_types_pkg::spike_vec_t spikes,
    input  snn_types_pkg::tstep_t   cur_tstep,
    output logic                    busy,
    output snn_types_pkg::aer_out_t aer_out_addr,
    output logic                    aer_out_req,
    input  logic                    aer_out_ack
);
    import snn_types_pkg::*;
    import snn_ctrl_pkg::*;

    link_state_t state;
    spike_vec_t  pend_q;      // spikes not yet sent
    tstep_t      tstep_q;     // step of the loaded vector
    post_idx_t   low_idx;
    logic        ack_s1;
    logic        ack_s2;      // synchronized ack
    logic        send;

    // lowest pending index goes first
    always_comb begin
        low_idx = '0;
        for (int i = $bits(spike_vec_t) - 1; i >= 0; i--) begin
            if (pend_q[i]) low_idx = post_idx_t'(i);
        end
    end

    assign send = (state == link_idle) && !out_load && (pend_q != '0);
    assign busy = (state != link_idle) || (pend_q != '0);   // zero load stays idle

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ack_s1      <= 1'b0;
            ack_s2      <= 1'b0;
            state       <= link_idle;
            pend_q      <= '0;
            aer_out_req <= 1'b0;
        end else begin
            ack_s1 <= aer_out_ack;
            ack_s2 <= ack_s1;
            case (state)
                link_idle: begin
                    if (out_load) begin
                        pend_q <= spikes;
                    end else if (send) begin
                        pend_q[low_idx] <= 1'b0;
                        aer_out_req     <= 1'b1;
                        state           <= link_req_wait;
                    end
                end
                link_req_wait: if (ack_s2) begin    // receiver took it
                    aer_out_req <= 1'b0;
                    state       <= link_ack_wait;
                end
                link_ack_wait: if (!ack_s2) state <= link_idle;
                default:       state <= link_idle;
            endcase
        end
    end

    // payload, held for the whole handshake
    always_ff @(posedge CLK) begin
        if (state == link_idle && out_load) tstep_q <= cur_tstep;
        if (send) aer_out_addr <= {tstep_q, low_idx};
    end

endmodule

`default_nettype wire

// ==== verilog/snn_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module snn_core_top (
    input  logic                       CLK,
    input  logic                       arst_n,
    // AER in
    input  snn_types_pkg::aer_in_t     aer_in_addr,
    input  logic                       aer_in_req,
    output logic                       aer_in_ack,
    // AER out
    output snn_types_pkg::aer_out_t    aer_out_addr,
    output logic                       aer_out_req,
    input  logic                       aer_out_ack,
    // weight load
    input  logic                       wt_we,
    input  snn_types_pkg::pre_addr_t   wt_addr,
    input  snn_types_pkg::weight_row_t wt_data,
    // sample result
    output logic                       one_sample_finish,
    output snn_types_pkg::goodness_t   goodness
);
    import snn_types_pkg::*;

    // --------------------
    // internal nets
    // --------------------
    logic        push, pop, fifo_empty, fifo_full;
    aer_in_t     push_data, fifo_head;
    logic        row_rd, integrate, fire, sample_end;
    pre_addr_t   row_addr;
    weight_row_t row_data;
    spike_vec_t  spikes;
    logic        out_load, out_busy;
    tstep_t      cur_tstep;

    aer_in_rx u_aer_in_rx (
        .CLK, .arst_n, .aer_in_addr, .aer_in_req, .aer_in_ack,
        .fifo_full (fifo_full), .push (push), .push_data (push_data)
    );

    event_scheduler u_event_scheduler (
        .CLK, .arst_n, .push, .pop, .push_data,
        .head (fifo_head), .empty (fifo_empty), .full (fifo_full)
    );

    snn_controller u_snn_controller (
        .CLK, .arst_n, .empty (fifo_empty), .head (fifo_head), .pop,
        .row_rd, .row_addr, .integrate, .fire, .sample_end,
        .out_busy, .out_load, .cur_tstep, .one_sample_finish
    );

    synapse_mem u_synapse_mem (
        .CLK, .wt_we, .wt_addr, .wt_data, .row_rd, .row_addr, .row_data
    );

    neuron_array u_neuron_array (
        .CLK, .arst_n, .row_data, .integrate, .fire, .sample_end, .spikes, .goodness
    );

    aer_out_tx u_aer_out_tx (
        .CLK, .arst_n, .out_load, .spikes, .cur_tstep, .busy (out_busy),
        .aer_out_addr, .aer_out_req, .aer_out_ack
    );

endmodule

`default_nettype wire

// ==== bench/snn_core_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module snn_core_props (
    input logic                    CLK,
    input logic                    arst_n,
    input logic                    aer_in_req,
    input logic                    aer_in_ack,
    input snn_types_pkg::aer_out_t aer_out_addr,
    input logic                    aer_out_req,
    input logic                    aer_out_ack,
    input logic                    one_sample_finish
);

    // --------------------
    // four-phase links
    // --------------------
    in_ack_held: assert property (@(posedge CLK) disable iff (!arst_n)
        aer_in_ack && aer_in_req |=> aer_in_ack)   // receiver side, return to zero
        else $error("aer_in_ack fell before aer_in_req fell");

    out_req_held: assert property (@(posedge CLK) disable iff (!arst_n)
        aer_out_req && !aer_out_ack |=> aer_out_req)
        else $error("aer_out_req fell before aer_out_ack rose");

    // payload frozen for the whole request phase
    out_addr_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        aer_out_req |=> !aer_out_req || $stable(aer_out_addr))
        else $error("aer_out_addr changed while aer_out_req high");

    // end-of-sample marker
    finish_single: assert property (@(posedge CLK) disable iff (!arst_n)
        one_sample_finish |=> !one_sample_finish)
        else $error("one_sample_finish longer than one cycle");

endmodule

`default_nettype wire

// ==== bench/snn_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "snn_macros.svh"

module snn_core_tb;
    import snn_types_pkg::*;

    localparam int      NP     = `SNN_POST_NEURONS;
    localparam int      MEMMAX = 2 ** (`SNN_MEM_WIDTH - 1) - 1;
    localparam int      MEMMIN = -(2 ** (`SNN_MEM_WIDTH - 1));
    localparam aer_in_t MARKER = {1'b1, {$bits(pre_addr_t){1'b0}}};   // time-step marker

    logic        CLK;
    logic        arst_n;
    aer_in_t     aer_in_addr;
    logic        aer_in_req;
    logic        aer_in_ack;
    aer_out_t    aer_out_addr;
    logic        aer_out_req;
    logic        aer_out_ack;
    logic        wt_we;
    pre_addr_t   wt_addr;
    weight_row_t wt_data;
    logic        one_sample_finish;
    goodness_t   goodness;

    int        wts [`SNN_PRE_NEURONS][NP];   // model copy of the weights
    aer_in_t   ev_q[$];                      // events of the sample being run
    aer_out_t  exp_q[$];
    aer_out_t  got_q[$];
    goodness_t exp_good;
    goodness_t fin_good;                     // goodness seen with the finish pulse
    int        fin_cnt = 0;
    int        ack_delay = 1;                // receiver ack delay, in cycles
    int        err_cnt = 0;
    int        chk_cnt = 0;
    int        test_cnt = 0;
    int        err_mark = 0;
    int        cycle_cnt = 0;
    int        limit_cycles = 2000;          // margin, grows with each sample
    integer    seed = 32'hdbf6;

    snn_core_top i_dut (.*);

    bind snn_core_top snn_core_props i_props (
        .CLK (CLK), .arst_n (arst_n), .aer_in_req (aer_in_req), .aer_in_ack (aer_in_ack),
        .aer_out_addr (aer_out_addr), .aer_out_req (aer_out_req),
        .aer_out_ack (aer_out_ack), .one_sample_finish (one_sample_finish)
    );

    // --------------------
    // clock, watchdog, monitors
    // --------------------
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns
    end

    initial begin
        while (cycle_cnt <= limit_cycles) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: the run got stuck and was stopped after %0d cycles", cycle_cnt);
        $display("Test FAILED");
        $finish;
    end

    always @(negedge CLK) begin
        if (one_sample_finish) begin
            fin_good = goodness;
            fin_cnt++;
        end
    end

    // output link receiver
    initial begin
        aer_out_ack = 1'b0;
        forever begin
            @(negedge CLK);
            if (aer_out_req) begin
                got_q.push_back(aer_out_addr);
                repeat (ack_delay) @(negedge CLK);
                aer_out_ack = 1'b1;
                while (aer_out_req) @(negedge CLK);
                aer_out_ack = 1'b0;   // return to zero
            end
        end
    end

    // --------------------
    // link and memory drivers
    // --------------------
    task automatic send_event(input aer_in_t ev);
        @(negedge CLK);
        aer_in_addr = ev;
        aer_in_req  = 1'b1;
        while (!aer_in_ack) @(negedge CLK);   // held off while queue is full
        aer_in_req = 1'b0;
        while (aer_in_ack) @(negedge CLK);
    endtask

    task automatic write_row(input int a, input int w0, input int w1, input int w2,
                             input int w3);
        @(negedge CLK);
        wt_we   = 1'b1;
        wt_addr = pre_addr_t'(a);
        wt_data = {weight_t'(w3), weight_t'(w2), weight_t'(w1), weight_t'(w0)};
        @(negedge CLK);
        wt_we = 1'b0;
        wts[a][0] = w0;
        wts[a][1] = w1;
        wts[a][2] = w2;
        wts[a][3] = w3;
    endtask

    function automatic void add_event(input int n);
        ev_q.push_back(aer_in_t'(n));
    endfunction

    function automatic void add_markers(input int k);
        repeat (k) ev_q.push_back(MARKER);
    endfunction

    function automatic int rnd_weight();
        return $random(seed) % 61 + 20;   // -40 .. 80
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic int saturate(input int v);
        if (v > MEMMAX) return MEMMAX;
        if (v < MEMMIN) return MEMMIN;
        return v;
    endfunction

    task automatic predict_sample();
        int mem [NP];
        int cnt [NP];
        int t;
        int sum;
        exp_q.delete();
        t   = 0;
        sum = 0;
        for (int i = 0; i < NP; i++) begin
            mem[i] = 0;
            cnt[i] = 0;
        end
        foreach (ev_q[k]) begin
            if (ev_q[k][$bits(aer_in_t)-1]) begin   // marker, fire in index order
                for (int i = 0; i < NP; i++) begin
                    if (mem[i] >= `SNN_THRESHOLD) begin
                        exp_q.push_back({tstep_t'(t), post_idx_t'(i)});
                        mem[i] = 0;
                        cnt[i]++;
                    end
                end
                t++;
            end else begin
                for (int i = 0; i < NP; i++)
                    mem[i] = saturate(mem[i] + wts[ev_q[k][$bits(pre_addr_t)-1:0]][i]);
            end
        end
        for (int i = 0; i < NP; i++) sum += cnt[i] * cnt[i];
        exp_good = goodness_t'(sum);
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_aer_out(input int n, input aer_out_t got, input aer_out_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t aer_out_addr[%0d]: got %h expected %h", $time, n, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_goodness(input goodness_t got, input goodness_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t goodness: got %0d expected %0d", $time, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // send the queued events, wait for the finish pulse, compare
    task automatic run_sample();
        int fin_before;
        limit_cycles += 40 * ev_q.size();
        predict_sample();
        got_q.delete();
        fin_before = fin_cnt;
        foreach (ev_q[k]) send_event(ev_q[k]);
        while (fin_cnt == fin_before) @(negedge CLK);
        if (got_q.size() != exp_q.size()) begin
            $display("at %0t the core sent %0d output events where %0d were expected",
                     $time, got_q.size(), exp_q.size());
            err_cnt++;
        end
        foreach (exp_q[k]) if (k < got_q.size()) check_aer_out(k, got_q[k], exp_q[k]);
        check_goodness(fin_good, exp_good);
        ev_q.delete();
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("%s: done, %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic reset_and_idle_sample();
        check_level("aer_in_ack", aer_in_ack, 1'b0);
        check_level("aer_out_req", aer_out_req, 1'b0);
        check_level("one_sample_finish", one_sample_finish, 1'b0);
        add_markers(`SNN_TIME_STEPS);   // no neuron events at all
        run_sample();
    endtask

    task automatic directed_firing();
        write_row(0, 70, 40, 10, -20);
        write_row(1, 0, 30, 64, 50);
        add_event(0);
        add_markers(1);
        add_event(1);
        add_markers(1);
        add_event(1);
        add_event(1);
        add_markers(1);
        add_event(0);
        add_markers(1);
        run_sample();
    endtask

    task automatic membrane_saturation();
        write_row(2, 127, 127, -128, -128);
        write_row(3, -128, -128, 127, 127);
        repeat (17) add_event(2);   // past both limits
        repeat (16) add_event(3);
        add_markers(1);
        add_event(3);               // fires only from the clamped floor
        add_markers(3);
        run_sample();
    endtask

    task automatic sample_boundary();
        write_row(4, 63, 100, 0, 0);
        write_row(5, 1, 0, 0, 0);
        add_event(4);               // neuron 0 parked one below threshold
        add_markers(`SNN_TIME_STEPS);
        run_sample();
        add_event(5);               // would reach 64 without the clear
        add_markers(`SNN_TIME_STEPS);
        run_sample();
    endtask

    task automatic output_back_pressure();
        ack_delay = 30;
        // a lost event moves some neuron off its threshold
        write_row(6, 60, 60, 60, 60);
        write_row(7, 1, 2, 3, 4);
        add_event(6);
        add_event(6);
        add_markers(1);             // all four fire, slow drain
        add_event(6);
        add_event(7);
        add_markers(1);             // core parks here while the queue fills
        add_event(7);
        add_event(7);
        add_event(7);
        add_markers(1);
        add_event(6);
        add_event(7);
        add_event(7);
        add_markers(1);             // burst of 14, deeper than the queue
        run_sample();
        ack_delay = 1;
    endtask

    task automatic random_samples();
        int k;
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < `SNN_PRE_NEURONS; a++)
                write_row(a, rnd_weight(), rnd_weight(), rnd_weight(), rnd_weight());
            for (int t = 0; t < `SNN_TIME_STEPS; t++) begin
                k = $unsigned($random(seed)) % 4;
                repeat (k) add_event($unsigned($random(seed)) % `SNN_PRE_NEURONS);
                add_markers(1);
            end
            ack_delay = $unsigned($random(seed)) % 5;
            run_sample();
        end
        ack_delay = 1;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        arst_n      = 1'b0;
        aer_in_addr = '0;
        aer_in_req  = 1'b0;
        wt_we       = 1'b0;
        wt_addr     = '0;
        wt_data     = '0;
        for (int a = 0; a < `SNN_PRE_NEURONS; a++)
            for (int i = 0; i < NP; i++) wts[a][i] = 0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        repeat (2) @(negedge CLK);

        reset_and_idle_sample();
        report_test("reset_and_idle_sample");
        directed_firing();
        report_test("directed_firing");
        membrane_saturation();
        report_test("membrane_saturation");
        sample_boundary();
        report_test("sample_boundary");
        output_back_pressure();
        report_test("output_back_pressure");
        random_samples();
        report_test("random_samples");

        $display("tests run: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
verilog/snn_types_pkg.sv
verilog/snn_ctrl_pkg.sv
verilog/aer_in_rx.sv
verilog/event_scheduler.sv
verilog/snn_controller.sv
verilog/synapse_mem.sv
verilog/neuron_array.sv
verilog/aer_out_tx.sv
verilog/snn_core_top.sv
bench/snn_core_props.sv
bench/snn_core_tb.sv
